/* hdl/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// register file geometry
`define DS_NUM_REGS 32
`define DS_LINK_REG 5'd31   // jal return address

// external interrupt lines seen by the stage
`define DS_INT_BITS 8

// exception codes, cause register encoding
`define DS_EXC_INT  5'd0
`define DS_EXC_SYS  5'd8
`define DS_EXC_BP   5'd9
`define DS_EXC_RI   5'd10
`define DS_EXC_NONE 5'd31   // nothing raised

`endif

/* hdl/decode_pkg.sv */
`include "decode_defs.svh"

package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [`DS_INT_BITS-1:0] int_vec_t;

    // one-hot, bit 0 add, 1 sub, 2 slt, 3 sltu, 4 and, 5 nor, 6 or, 7 xor,
    // 8 sll, 9 srl, 10 sra
    typedef logic [10:0] alu_op_t;

    typedef enum logic [2:0] {br_none, br_beq, br_bne, br_j, br_jal, br_jr} br_kind_e;

    typedef enum logic [1:0] {int_idle, int_marking, int_rollback} int_state_e;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        logic      fetch_ex;
        exc_code_t fetch_exc;
        logic      in_delay_slot;
    } fetch_bundle_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_write_t;

    // is_load only meaningful on the exe source
    typedef struct packed {
        reg_addr_t dest;
        word_t     result;
        logic      is_load;
    } fwd_source_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        word_t     src2_imm;    // already extended, or 8 for jal
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      load_op;
        br_kind_e  br_kind;
        word_t     br_target;
        logic      reads_rs;
        logic      reads_rt;
        logic      is_syscall;
        logic      is_break;
        logic      defined;
    } decoded_t;

    typedef struct packed {
        decoded_t  ctrl;
        word_t     rs_value;
        word_t     rt_value;
        word_t     src1_value;
        word_t     src2_value;
        word_t     pc;
        logic      in_delay_slot;
        logic      ex;
        exc_code_t exc_code;
    } issue_bundle_t;

endpackage

/* hdl/decode_latch.sv */
`timescale 1ns/1ps

module decode_latch (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      fs_valid,
    input  decode_pkg::fetch_bundle_t fs_bundle,
    input  logic                      ready_go,
    input  logic                      es_allowin,
    output decode_pkg::fetch_bundle_t held,
    output logic                      ds_valid,
    output logic                      ds_allowin
);

    // empty, or the current instruction leaves this cycle
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            held <= '0;
        end else if (fs_valid && ds_allowin) begin
            held <= fs_bundle;
        end
    end

    // a stall only ever comes from a held instruction
    empty_not_stalled_a: assert property (@(posedge clk) disable iff (reset)
        !ds_valid |-> ready_go);

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module inst_decoder (
    input  decode_pkg::word_t    inst,
    input  decode_pkg::word_t    pc,
    output decode_pkg::decoded_t ctrl
);
    import decode_pkg::*;

    logic [5:0]  op;
    logic [5:0]  func;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm;
    logic        is_rtype;
    logic i_addu, i_subu, i_add, i_sub, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic i_sll, i_srl, i_sra, i_jr, i_syscall, i_break;
    logic i_addiu, i_addi, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_lw, i_sw, i_beq, i_bne, i_j, i_jal;
    logic imm_sign, imm_zero, dst_is_rt, no_dest;
    word_t pc_plus4;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];

    assign is_rtype  = (op == 6'h00);
    assign i_addu    = is_rtype && func == 6'h21 && sa == 5'd0;
    assign i_subu    = is_rtype && func == 6'h23 && sa == 5'd0;
    assign i_add     = is_rtype && func == 6'h20 && sa == 5'd0;
    assign i_sub     = is_rtype && func == 6'h22 && sa == 5'd0;
    assign i_slt     = is_rtype && func == 6'h2a && sa == 5'd0;
    assign i_sltu    = is_rtype && func == 6'h2b && sa == 5'd0;
    assign i_and     = is_rtype && func == 6'h24 && sa == 5'd0;
    assign i_or      = is_rtype && func == 6'h25 && sa == 5'd0;
    assign i_xor     = is_rtype && func == 6'h26 && sa == 5'd0;
    assign i_nor     = is_rtype && func == 6'h27 && sa == 5'd0;
    assign i_sll     = is_rtype && func == 6'h00 && rs == 5'd0;   // also covers nop
    assign i_srl     = is_rtype && func == 6'h02 && rs == 5'd0;
    assign i_sra     = is_rtype && func == 6'h03 && rs == 5'd0;
    assign i_jr      = is_rtype && func == 6'h08 && rt == 5'd0 && rd == 5'd0 && sa == 5'd0;
    assign i_syscall = is_rtype && func == 6'h0c;
    assign i_break   = is_rtype && func == 6'h0d;
    assign i_addi    = (op == 6'h08);
    assign i_addiu   = (op == 6'h09);
    assign i_slti    = (op == 6'h0a);
    assign i_sltiu   = (op == 6'h0b);
    assign i_andi    = (op == 6'h0c);
    assign i_ori     = (op == 6'h0d);
    assign i_xori    = (op == 6'h0e);
    assign i_lui     = (op == 6'h0f) && rs == 5'd0;
    assign i_lw      = (op == 6'h23);
    assign i_sw      = (op == 6'h2b);
    assign i_beq     = (op == 6'h04);
    assign i_bne     = (op == 6'h05);
    assign i_j       = (op == 6'h02);
    assign i_jal     = (op == 6'h03);

    assign imm_sign  = i_addiu || i_addi || i_slti || i_sltiu || i_lw || i_sw;
    assign imm_zero  = i_andi || i_ori || i_xori;
    assign dst_is_rt = imm_sign && !i_sw || imm_zero || i_lui;
    assign no_dest   = i_sw || i_beq || i_bne || i_jr || i_j || i_syscall || i_break;
    assign pc_plus4  = pc + 32'd4;

    always_comb begin
        ctrl.alu_op[0]  = i_addu || i_add || i_addiu || i_addi || i_lw || i_sw || i_jal;
        ctrl.alu_op[1]  = i_subu || i_sub;
        ctrl.alu_op[2]  = i_slt || i_slti;
        ctrl.alu_op[3]  = i_sltu || i_sltiu;
        ctrl.alu_op[4]  = i_and || i_andi;
        ctrl.alu_op[5]  = i_nor;
        ctrl.alu_op[6]  = i_or || i_ori || i_lui;   // lui is or with r0
        ctrl.alu_op[7]  = i_xor || i_xori;
        ctrl.alu_op[8]  = i_sll;
        ctrl.alu_op[9]  = i_srl;
        ctrl.alu_op[10] = i_sra;

        ctrl.src1_is_sa  = i_sll || i_srl || i_sra;
        ctrl.src1_is_pc  = i_jal;
        ctrl.src2_is_imm = imm_sign || imm_zero || i_lui || i_jal;
        if (i_jal)
            ctrl.src2_imm = 32'd8;              // link address pc + 8
        else if (i_lui)
            ctrl.src2_imm = {imm, 16'h0000};
        else if (imm_zero)
            ctrl.src2_imm = {16'h0000, imm};
        else
            ctrl.src2_imm = {{16{imm[15]}}, imm};

        if (i_jal)
            ctrl.dest = `DS_LINK_REG;
        else if (dst_is_rt)
            ctrl.dest = rt;
        else if (no_dest)
            ctrl.dest = 5'd0;
        else
            ctrl.dest = rd;

        ctrl.defined = i_addu || i_subu || i_add || i_sub || i_slt || i_sltu || i_and ||
                       i_or || i_xor || i_nor || i_sll || i_srl || i_sra || i_jr ||
                       i_syscall || i_break || imm_sign || imm_zero || i_lui ||
                       i_beq || i_bne || i_j || i_jal;
        ctrl.gr_we      = ctrl.defined && !no_dest;
        ctrl.mem_we     = i_sw;
        ctrl.load_op    = i_lw;
        ctrl.reads_rs   = ctrl.defined && !ctrl.src1_is_sa && !i_lui && !i_j && !i_jal &&
                          !i_syscall && !i_break;
        ctrl.reads_rt   = ctrl.defined && !dst_is_rt && !i_jr && !i_j && !i_jal &&
                          !i_syscall && !i_break;
        ctrl.is_syscall = i_syscall;
        ctrl.is_break   = i_break;

        if (i_beq)
            ctrl.br_kind = br_beq;
        else if (i_bne)
            ctrl.br_kind = br_bne;
        else if (i_j)
            ctrl.br_kind = br_j;
        else if (i_jal)
            ctrl.br_kind = br_jal;
        else if (i_jr)
            ctrl.br_kind = br_jr;
        else
            ctrl.br_kind = br_none;

        // jr target is the rs value, resolved downstream
        if (i_beq || i_bne)
            ctrl.br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
        else if (i_j || i_jal)
            ctrl.br_target = {pc[31:28], inst[25:0], 2'b00};
        else
            ctrl.br_target = '0;
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  decode_pkg::wb_write_t wr,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);
    import decode_pkg::*;

    word_t regs [1:`DS_NUM_REGS-1];   // r0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `DS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.waddr != 5'd0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* hdl/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ds_valid,
    input  decode_pkg::word_t       inst,
    input  decode_pkg::decoded_t    ctrl,
    input  decode_pkg::wb_write_t   wb_write,
    input  decode_pkg::fwd_source_t exe_fwd,
    input  decode_pkg::fwd_source_t mem_fwd,
    input  decode_pkg::fwd_source_t wb_fwd,
    output decode_pkg::word_t       rs_value,
    output decode_pkg::word_t       rt_value,
    output logic                    load_stall
);
    import decode_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rf_rs;
    word_t     rf_rt;
    logic      rs_hit_load;
    logic      rt_hit_load;

    // youngest writer wins, r0 never matches
    function automatic word_t fwd_select(input reg_addr_t idx, input logic used,
                                         input word_t rf_val, input fwd_source_t exe,
                                         input fwd_source_t mem, input fwd_source_t wb);
        logic live;
        live = used && (idx != 5'd0);
        if (live && idx == exe.dest)
            return exe.result;
        if (live && idx == mem.dest)
            return mem.result;
        if (live && idx == wb.dest)
            return wb.result;
        return rf_val;
    endfunction

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    register_file register_file_i (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs),
        .raddr2 (rt),
        .wr     (wb_write),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    assign rs_value = fwd_select(rs, ctrl.reads_rs, rf_rs, exe_fwd, mem_fwd, wb_fwd);
    assign rt_value = fwd_select(rt, ctrl.reads_rt, rf_rt, exe_fwd, mem_fwd, wb_fwd);

    // load data not ready until mem
    assign rs_hit_load = ctrl.reads_rs && rs != 5'd0 && rs == exe_fwd.dest;
    assign rt_hit_load = ctrl.reads_rt && rt != 5'd0 && rt == exe_fwd.dest;
    assign load_stall  = ds_valid && exe_fwd.is_load && (rs_hit_load || rt_hit_load);

    // stalled instruction stays put until the load result is forwardable
    stall_holds_inst_a: assert property (@(posedge clk) disable iff (reset)
        load_stall |=> !ds_valid || $stable(inst));

endmodule

/* hdl/exception_check.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module exception_check (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ds_valid,
    input  logic                  leaving,
    input  logic                  fetch_ex,
    input  decode_pkg::exc_code_t fetch_exc,
    input  decode_pkg::decoded_t  ctrl,
    input  logic                  int_enable,
    input  logic                  in_exception,
    input  decode_pkg::int_vec_t  int_pending,
    input  decode_pkg::int_vec_t  int_mask,
    output logic                  ex,
    output decode_pkg::exc_code_t exc_code
);
    import decode_pkg::*;

    int_state_e state;
    int_state_e next_state;
    logic       has_int;
    logic       int_mark;

    assign has_int = |(int_pending & int_mask) && int_enable && !in_exception;

    // mark exactly one instruction per interrupt assertion
    always_comb begin
        next_state = state;
        int_mark   = 1'b0;
        case (state)
            int_idle: begin
                if (has_int && ds_valid) begin
                    int_mark   = 1'b1;
                    next_state = leaving ? int_rollback : int_marking;
                end
            end
            int_marking: begin
                int_mark = 1'b1;            // held until it issues
                if (leaving)
                    next_state = int_rollback;
            end
            int_rollback: begin
                if (!has_int)
                    next_state = int_idle;
            end
            default: next_state = int_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= int_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        if (fetch_ex)
            exc_code = fetch_exc;
        else if (int_mark)
            exc_code = `DS_EXC_INT;
        else if (!ctrl.defined)
            exc_code = `DS_EXC_RI;
        else if (ctrl.is_syscall)
            exc_code = `DS_EXC_SYS;
        else if (ctrl.is_break)
            exc_code = `DS_EXC_BP;
        else
            exc_code = `DS_EXC_NONE;
    end

    assign ex = fetch_ex || int_mark || !ctrl.defined || ctrl.is_syscall || ctrl.is_break;

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fs_valid,
    input  decode_pkg::fetch_bundle_t fs_bundle,
    output logic                      ds_allowin,
    output logic                      ds_valid_out,
    output decode_pkg::issue_bundle_t ds_bundle,
    input  logic                      es_allowin,
    input  logic                      flush,
    input  decode_pkg::wb_write_t     wb_write,
    input  decode_pkg::fwd_source_t   exe_fwd,
    input  decode_pkg::fwd_source_t   mem_fwd,
    input  decode_pkg::fwd_source_t   wb_fwd,
    input  logic                      int_enable,
    input  logic                      in_exception,
    input  decode_pkg::int_vec_t      int_pending,
    input  decode_pkg::int_vec_t      int_mask
);
    import decode_pkg::*;

    fetch_bundle_t held;
    decoded_t      ctrl;
    word_t         rs_value;
    word_t         rt_value;
    logic          ds_valid;
    logic          load_stall;
    logic          ready_go;
    logic          leaving;
    logic          ex;
    exc_code_t     exc_code;

    assign ready_go     = !load_stall;
    assign ds_valid_out = ds_valid && ready_go;
    assign leaving      = ds_valid_out && es_allowin;

    decode_latch decode_latch_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .fs_valid   (fs_valid),
        .fs_bundle  (fs_bundle),
        .ready_go   (ready_go),
        .es_allowin (es_allowin),
        .held       (held),
        .ds_valid   (ds_valid),
        .ds_allowin (ds_allowin)
    );

    inst_decoder inst_decoder_i (
        .inst (held.inst),
        .pc   (held.pc),
        .ctrl (ctrl)
    );

    operand_forward operand_forward_i (
        .clk        (clk),
        .reset      (reset),
        .ds_valid   (ds_valid),
        .inst       (held.inst),
        .ctrl       (ctrl),
        .wb_write   (wb_write),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    exception_check exception_check_i (
        .clk          (clk),
        .reset        (reset),
        .ds_valid     (ds_valid),
        .leaving      (leaving),
        .fetch_ex     (held.fetch_ex),
        .fetch_exc    (held.fetch_exc),
        .ctrl         (ctrl),
        .int_enable   (int_enable),
        .in_exception (in_exception),
        .int_pending  (int_pending),
        .int_mask     (int_mask),
        .ex           (ex),
        .exc_code     (exc_code)
    );

    always_comb begin
        ds_bundle.ctrl     = ctrl;
        ds_bundle.rs_value = rs_value;
        ds_bundle.rt_value = rt_value;
        if (ctrl.src1_is_sa)
            ds_bundle.src1_value = {27'd0, held.inst[10:6]};   // shift amount
        else if (ctrl.src1_is_pc)
            ds_bundle.src1_value = held.pc;
        else
            ds_bundle.src1_value = rs_value;
        ds_bundle.src2_value    = ctrl.src2_is_imm ? ctrl.src2_imm : rt_value;
        ds_bundle.pc            = held.pc;
        ds_bundle.in_delay_slot = held.in_delay_slot;
        ds_bundle.ex            = ex;
        ds_bundle.exc_code      = exc_code;
    end

endmodule

/* testbench/decode_tests.svh */
task automatic check_ctrl(input int op_bit, input reg_addr_t dest, input word_t src1,
                          input word_t src2);
    check_word("ds_bundle.ctrl.alu_op", 32'(1 << op_bit), 32'(ds_bundle.ctrl.alu_op));
    check_word("ds_bundle.ctrl.dest", 32'(dest), 32'(ds_bundle.ctrl.dest));
    check_word("ds_bundle.src1_value", src1, ds_bundle.src1_value);
    check_word("ds_bundle.src2_value", src2, ds_bundle.src2_value);
endtask

task automatic check_exc(input logic ex, input exc_code_t code);
    check_word("ds_bundle.ex", 32'(ex), 32'(ds_bundle.ex));
    check_word("ds_bundle.exc_code", 32'(code), 32'(ds_bundle.exc_code));
endtask

task automatic test_decode();
    word_t       pc;
    logic [15:0] imm;
    logic [25:0] idx;
    begin_test();
    @(negedge clk);
    check_word("ds_valid_out", 32'd0, 32'(ds_valid_out));   // state after reset
    check_word("ds_allowin", 32'd1, 32'(ds_allowin));
    pc  = 32'h0040_0100;
    imm = 16'h8000 | 16'($urandom());   // negative, so extension shows
    run_inst(pc, encode_i(6'h09, 5'd1, 5'd2, imm));   // addiu
    check_word("issue_delay", 32'd0, 32'(issue_delay));
    check_ctrl(op_add, 5'd2, 32'd0, {16'hffff, imm});
    run_inst(pc, encode_i(6'h0d, 5'd0, 5'd3, imm));   // ori
    check_ctrl(op_or, 5'd3, 32'd0, {16'h0000, imm});
    run_inst(pc, encode_i(6'h0f, 5'd0, 5'd4, imm));   // lui
    check_ctrl(op_or, 5'd4, 32'd0, {imm, 16'h0000});
    run_inst(pc, encode_r(5'd1, 5'd2, 5'd5, 5'd0, 6'h21));   // addu
    check_ctrl(op_add, 5'd5, 32'd0, 32'd0);
    run_inst(pc, encode_r(5'd0, 5'd2, 5'd6, 5'd7, 6'h00));   // sll by 7
    check_ctrl(op_sll, 5'd6, 32'd7, 32'd0);
    idx = 26'($urandom());
    run_inst(pc, encode_j(6'h03, idx));   // jal
    check_ctrl(op_add, 5'd31, pc, 32'd8);
    run_inst(pc, encode_i(6'h04, 5'd1, 5'd2, imm));   // beq, backward
    check_word("ds_bundle.ctrl.br_target",
               pc + 32'd4 - ((32'h0001_0000 - 32'(imm)) << 2),
               ds_bundle.ctrl.br_target);
    run_inst(32'h9000_0040, encode_j(6'h02, idx));   // j keeps pc[31:28]
    check_word("ds_bundle.ctrl.br_target", {4'h9, idx, 2'b00}, ds_bundle.ctrl.br_target);
    finish_test("decode");
endtask

task automatic test_forwarding();
    word_t vals [1:8];
    word_t res_exe;
    word_t res_mem;
    word_t res_wb;
    begin_test();
    for (int r = 1; r <= 8; r++) begin
        vals[r] = $urandom();
        @(posedge clk);
        #1;
        wb_write = '{we: 1'b1, waddr: 5'(r), wdata: vals[r]};
    end
    @(posedge clk);
    #1;
    wb_write = '0;
    es_allowin = 1'b0;   // keep the addu in the stage
    run_inst(32'h0040_0200, encode_r(5'd3, 5'd4, 5'd9, 5'd0, 6'h21));
    check_word("ds_bundle.rs_value", vals[3], ds_bundle.rs_value);
    check_word("ds_bundle.rt_value", vals[4], ds_bundle.rt_value);
    check_word("ds_bundle.src1_value", vals[3], ds_bundle.src1_value);
    check_word("ds_bundle.src2_value", vals[4], ds_bundle.src2_value);
    res_exe = $urandom();
    res_mem = ~res_exe;
    res_wb  = res_exe ^ 32'h5a5a_5a5a;
    @(posedge clk);
    #1;
    exe_fwd = '{dest: 5'd3, result: res_exe, is_load: 1'b0};
    mem_fwd = '{dest: 5'd3, result: res_mem, is_load: 1'b0};
    wb_fwd  = '{dest: 5'd3, result: res_wb, is_load: 1'b0};
    @(negedge clk);
    check_word("ds_bundle.rs_value", res_exe, ds_bundle.rs_value);
    @(posedge clk);
    #1;
    exe_fwd = '0;
    @(negedge clk);
    check_word("ds_bundle.rs_value", res_mem, ds_bundle.rs_value);
    @(posedge clk);
    #1;
    mem_fwd    = '0;
    es_allowin = 1'b1;
    @(negedge clk);
    check_word("ds_bundle.rs_value", res_wb, ds_bundle.rs_value);
    @(posedge clk);
    #1;
    // r0 reader with every source claiming dest 0
    exe_fwd = '{dest: 5'd0, result: res_exe, is_load: 1'b0};
    mem_fwd = '{dest: 5'd0, result: res_mem, is_load: 1'b0};
    wb_fwd  = '{dest: 5'd0, result: res_wb, is_load: 1'b0};
    run_inst(32'h0040_0204, encode_r(5'd0, 5'd4, 5'd9, 5'd0, 6'h21));
    check_word("ds_bundle.rs_value", 32'd0, ds_bundle.rs_value);
    check_word("ds_bundle.rt_value", vals[4], ds_bundle.rt_value);
    @(posedge clk);
    #1;
    exe_fwd = '0;
    mem_fwd = '0;
    wb_fwd  = '0;
    finish_test("forwarding");
endtask

task automatic test_load_stall();
    word_t ld;
    begin_test();
    ld      = $urandom();
    exe_fwd = '{dest: 5'd6, result: ld, is_load: 1'b1};
    issue_fetch(32'h0040_0300, encode_r(5'd5, 5'd6, 5'd10, 5'd0, 6'h21), 1'b0, 5'd0);
    repeat (4) begin
        @(negedge clk);
        check_word("ds_valid_out", 32'd0, 32'(ds_valid_out));
        check_word("ds_allowin", 32'd0, 32'(ds_allowin));
    end
    @(posedge clk);
    #1;
    exe_fwd.is_load = 1'b0;   // load data now forwardable
    @(negedge clk);
    check_word("ds_valid_out", 32'd1, 32'(ds_valid_out));
    check_word("ds_bundle.rt_value", ld, ds_bundle.rt_value);
    @(posedge clk);
    #1;
    exe_fwd = '0;
    finish_test("load_stall");
endtask

task automatic test_exceptions();
    begin_test();
    run_inst(32'h0040_0400, encode_r(5'd1, 5'd2, 5'd3, 5'd0, 6'h21));
    check_exc(1'b0, `DS_EXC_NONE);
    run_inst(32'h0040_0404, 32'hfc00_0000);   // opcode 0x3f not in the set
    check_exc(1'b1, `DS_EXC_RI);
    run_inst(32'h0040_0408, encode_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c));
    check_exc(1'b1, `DS_EXC_SYS);
    run_inst(32'h0040_040c, encode_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h0d));
    check_exc(1'b1, `DS_EXC_BP);
    issue_fetch(32'h0040_0411, 32'hfc00_0000, 1'b1, 5'd4);   // address error on fetch
    wait_issue();
    check_exc(1'b1, 5'd4);
    finish_test("exceptions");
endtask

task automatic test_interrupts();
    word_t nop;
    begin_test();
    nop         = encode_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h00);
    @(posedge clk);
    #1;
    int_mask    = 8'h04;
    int_pending = 8'h04;
    int_enable  = 1'b1;
    run_inst(32'h0040_0500, nop);
    check_exc(1'b1, `DS_EXC_INT);
    run_inst(32'h0040_0504, nop);
    check_exc(1'b0, `DS_EXC_NONE);
    run_inst(32'h0040_0508, nop);
    check_exc(1'b0, `DS_EXC_NONE);
    @(posedge clk);
    #1;
    int_pending = 8'h00;
    repeat (2) @(posedge clk);
    #1;
    int_pending = 8'h04;   // new assertion
    run_inst(32'h0040_050c, nop);
    check_exc(1'b1, `DS_EXC_INT);
    run_inst(32'h0040_0510, nop);
    check_exc(1'b0, `DS_EXC_NONE);
    @(posedge clk);
    #1;
    int_pending = 8'h00;
    repeat (2) @(posedge clk);
    #1;
    in_exception = 1'b1;
    int_pending  = 8'h04;
    run_inst(32'h0040_0514, nop);
    check_exc(1'b0, `DS_EXC_NONE);
    @(posedge clk);
    #1;
    int_pending  = 8'h00;
    in_exception = 1'b0;
    int_enable   = 1'b0;
    finish_test("interrupts");
endtask

task automatic test_backpressure_flush();
    issue_bundle_t snap;
    begin_test();
    es_allowin = 1'b0;
    run_inst(32'h0040_0600, encode_i(6'h09, 5'd1, 5'd7, 16'h1234));
    snap      = ds_bundle;
    @(posedge clk);
    #1;
    fs_valid  = 1'b1;   // a second instruction waits upstream
    fs_bundle = '{pc: 32'h0040_0604, inst: encode_i(6'h0d, 5'd0, 5'd8, 16'h00ff),
                  fetch_ex: 1'b0, fetch_exc: 5'd0, in_delay_slot: 1'b0};
    repeat (4) begin
        @(negedge clk);
        if (ds_bundle !== snap) begin
            $display("CHECK FAILED at %0t: ds_bundle expected %h got %h", $time,
                     snap, ds_bundle);
            errors++;
        end
        check_word("ds_valid_out", 32'd1, 32'(ds_valid_out));
        check_word("ds_allowin", 32'd0, 32'(ds_allowin));
    end
    @(posedge clk);
    #1;
    fs_valid = 1'b0;
    flush    = 1'b1;
    @(posedge clk);
    #1;
    flush      = 1'b0;
    es_allowin = 1'b1;
    @(negedge clk);
    check_word("ds_valid_out", 32'd0, 32'(ds_valid_out));
    run_inst(32'h0040_0700, encode_i(6'h0d, 5'd0, 5'd9, 16'h0f0f));
    check_word("ds_bundle.pc", 32'h0040_0700, ds_bundle.pc);
    check_word("ds_bundle.ctrl.dest", 32'd9, 32'(ds_bundle.ctrl.dest));
    finish_test("backpressure");
endtask

/* testbench/decode_stage_tb.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_stage_tb;
    import decode_pkg::*;

    localparam int num_tests  = 6;
    localparam int clk_period = 10;
    localparam int op_add     = 0;   // alu_op one-hot positions
    localparam int op_or      = 6;
    localparam int op_sll     = 8;

    logic          clk = 1'b0;
    logic          reset;
    logic          fs_valid;
    fetch_bundle_t fs_bundle;
    logic          ds_allowin;
    logic          ds_valid_out;
    issue_bundle_t ds_bundle;
    logic          es_allowin;
    logic          flush;
    wb_write_t     wb_write;
    fwd_source_t   exe_fwd;
    fwd_source_t   mem_fwd;
    fwd_source_t   wb_fwd;
    logic          int_enable;
    logic          in_exception;
    int_vec_t      int_pending;
    int_vec_t      int_mask;

    int errors       = 0;
    int error_mark   = 0;
    int tests_run    = 0;
    int failed_tests = 0;
    int issue_delay  = 0;   // extra cycles before ds_valid_out rose

    always #(clk_period / 2) clk = ~clk;

    decode_stage decode_stage_i (.*);

    function automatic word_t encode_r(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input logic [4:0] sa,
                                       input logic [5:0] func);
        return {6'h00, rs, rt, rd, sa, func};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encode_j(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    // hold fs_valid until the stage takes the instruction
    task automatic issue_fetch(input word_t pc, input word_t inst, input logic fex,
                               input exc_code_t fexc);
        logic taken;
        @(posedge clk);
        #1;
        fs_valid  = 1'b1;
        fs_bundle = '{pc: pc, inst: inst, fetch_ex: fex, fetch_exc: fexc,
                      in_delay_slot: 1'b0};
        do begin
            @(negedge clk);
            taken = ds_allowin;
            @(posedge clk);
            #1;
        end while (!taken);
        fs_valid = 1'b0;
    endtask

    // returns at the falling edge where ds_valid_out is seen high
    task automatic wait_issue();
        issue_delay = 0;
        @(negedge clk);
        while (!ds_valid_out && issue_delay < 20) begin
            @(negedge clk);
            issue_delay++;
        end
        if (!ds_valid_out) begin
            $display("ERROR at %0t: instruction never reached ds_valid_out", $time);
            errors++;
        end
    endtask

    task automatic run_inst(input word_t pc, input word_t inst);
        issue_fetch(pc, inst, 1'b0, 5'd0);
        wait_issue();
    endtask

    task automatic begin_test();
        error_mark = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == error_mark) begin
            $display("%-16s ok", name);
        end else begin
            $display("%-16s %0d errors", name, errors - error_mark);
            failed_tests++;
        end
    endtask

    `include "decode_tests.svh"

    initial begin
        void'($urandom(25307));
        reset        = 1'b1;
        fs_valid     = 1'b0;
        fs_bundle    = '0;
        es_allowin   = 1'b1;
        flush        = 1'b0;
        wb_write     = '0;
        exe_fwd      = '0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        int_enable   = 1'b0;
        in_exception = 1'b0;
        int_pending  = '0;
        int_mask     = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_decode();
        test_forwarding();
        test_load_stall();
        test_exceptions();
        test_interrupts();
        test_backpressure_flush();
        $display("summary: %0d tests run, %0d with errors, %0d check errors",
                 tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // each test gets a budget of 200 cycles
    initial begin
        #((16 + num_tests * 200) * clk_period);
        $display("watchdog expired before the test sequence completed");
        $display("tests failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
+incdir+testbench
hdl/decode_pkg.sv
hdl/decode_latch.sv
hdl/inst_decoder.sv
hdl/register_file.sv
hdl/operand_forward.sv
hdl/exception_check.sv
hdl/decode_stage.sv
testbench/decode_stage_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/decode_pkg.sv
      - hdl/decode_latch.sv
      - hdl/inst_decoder.sv
      - hdl/register_file.sv
      - hdl/operand_forward.sv
      - hdl/exception_check.sv
      - hdl/decode_stage.sv
  - target: test
    include_dirs:
      - hdl
      - testbench
    files:
      - testbench/decode_stage_tb.sv
